/* Bender.yml */
package:
  name: memCtrl

sources:
  - common/memCtrlPkg.sv
  - common/memAccessIf.sv
  - common/byteStreamIf.sv
  - design/memArbiter.sv
  - memSeq/byteSequencer.sv
  - memSeq/wordAssembler.sv
  - design/memCtrlTop.sv
  - target: simulation
    files:
      - sim/ramModel.sv
      - sim/memCtrl_props.sv
      - sim/memCtrlTb.sv

/* common/byteStreamIf.sv */
`default_nettype none

interface byteStreamIf;
    logic valid;
    // byte position within the word
    memCtrlPkg::len_t idx;
    memCtrlPkg::byte_t data;
    logic last;

    modport source (
        output valid,
        output idx,
        output data,
        output last
    );

    modport sink (
        input valid,
        input idx,
        input data,
        input last
    );
endinterface

`default_nettype wire

/* common/memAccessIf.sv */
`default_nettype none

interface memAccessIf;
    logic req;
    memCtrlPkg::memOp_e op;
    memCtrlPkg::addr_t addr;
    memCtrlPkg::len_t len;
    memCtrlPkg::word_t wdata;
    // one cycle, ends the access
    logic done;

    modport arbiter (
        output req,
        output op,
        output addr,
        output len,
        output wdata,
        input  done
    );

    modport sequencer (
        input  req,
        input  op,
        input  addr,
        input  len,
        input  wdata,
        output done
    );
endinterface

`default_nettype wire

/* common/memCtrlPkg.sv */
`default_nettype none

package memCtrlPkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int LEN_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [LEN_W-1:0] len_t;

    // every fetch is one full instruction
    localparam len_t INST_LEN = len_t'(4);

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } memOp_e;

    typedef enum logic {
        arbIdle,
        arbBusy
    } arbState_e;

    // data cache load/store select
    typedef enum logic {
        lsLoad,
        lsStore
    } lsSel_e;

endpackage

`default_nettype wire

/* design/memArbiter.sv */
`default_nettype none

module memArbiter (
    input  logic               clk,
    input  logic               rst,

    input  logic               i_instEn,
    input  memCtrlPkg::addr_t  i_instAddr,

    input  logic               i_dcEn,
    input  memCtrlPkg::lsSel_e i_dcLs,
    input  memCtrlPkg::len_t   i_dcLen,
    input  memCtrlPkg::word_t  i_dcData,
    input  memCtrlPkg::addr_t  i_dcAddr,

    input  memCtrlPkg::word_t  i_readWord,

    output logic               o_instDone,
    output memCtrlPkg::word_t  o_inst,
    output logic               o_dcDone,
    output memCtrlPkg::word_t  o_dcData,

    memAccessIf.arbiter        acc
);
    memCtrlPkg::arbState_e state;
    memCtrlPkg::memOp_e opQ;
    memCtrlPkg::addr_t addrQ;
    memCtrlPkg::len_t lenQ;
    memCtrlPkg::word_t wdataQ;
    logic anyReq;
    logic isFetch;

    assign anyReq = i_dcEn || i_instEn;
    assign isFetch = opQ == memCtrlPkg::opFetch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memCtrlPkg::arbIdle;
            opQ <= memCtrlPkg::opFetch;
        end else if (state == memCtrlPkg::arbIdle) begin
            if (i_dcEn) begin
                state <= memCtrlPkg::arbBusy;
                opQ <= (i_dcLs == memCtrlPkg::lsStore) ? memCtrlPkg::opStore
                                                        : memCtrlPkg::opLoad;
            end else if (i_instEn) begin
                state <= memCtrlPkg::arbBusy;
                opQ <= memCtrlPkg::opFetch;
            end
        end else if (acc.done) begin
            state <= memCtrlPkg::arbIdle;
        end
    end

    // access fields, latched on grant
    always_ff @(posedge clk) begin
        if (state == memCtrlPkg::arbIdle && anyReq) begin
            if (i_dcEn) begin
                addrQ <= i_dcAddr;
                lenQ <= i_dcLen;
                wdataQ <= i_dcData;
            end else begin
                addrQ <= i_instAddr;
                lenQ <= memCtrlPkg::INST_LEN;
            end
        end
    end

    assign acc.req = state == memCtrlPkg::arbBusy;
    assign acc.op = opQ;
    assign acc.addr = addrQ;
    assign acc.len = lenQ;
    assign acc.wdata = wdataQ;

    // result back to whoever was granted
    assign o_instDone = acc.done && isFetch;
    assign o_dcDone = acc.done && !isFetch;
    assign o_inst = isFetch ? i_readWord : '0;
    assign o_dcData = (opQ == memCtrlPkg::opLoad) ? i_readWord : '0;
endmodule

`default_nettype wire

/* design/memCtrlTop.sv */
`default_nettype none

module memCtrlTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rdy,
    input  logic               i_ioBufferFull,

    input  memCtrlPkg::byte_t  i_memData,
    output logic               o_memWrite,
    output memCtrlPkg::addr_t  o_memAddr,
    output memCtrlPkg::byte_t  o_memData,

    input  logic               i_instEn,
    input  memCtrlPkg::addr_t  i_instAddr,
    output logic               o_instDone,
    output memCtrlPkg::word_t  o_inst,

    input  logic               i_dcEn,
    input  memCtrlPkg::lsSel_e i_dcLs,
    input  memCtrlPkg::len_t   i_dcLen,
    input  memCtrlPkg::word_t  i_dcData,
    input  memCtrlPkg::addr_t  i_dcAddr,
    output logic               o_dcDone,
    output memCtrlPkg::word_t  o_dcData
);
    memCtrlPkg::word_t readWord;

    memAccessIf acc ();
    byteStreamIf bytes ();

    memArbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .i_instEn   (i_instEn),
        .i_instAddr (i_instAddr),
        .i_dcEn     (i_dcEn),
        .i_dcLs     (i_dcLs),
        .i_dcLen    (i_dcLen),
        .i_dcData   (i_dcData),
        .i_dcAddr   (i_dcAddr),
        .i_readWord (readWord),
        .o_instDone (o_instDone),
        .o_inst     (o_inst),
        .o_dcDone   (o_dcDone),
        .o_dcData   (o_dcData),
        .acc        (acc.arbiter)
    );

    byteSequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .acc            (acc.sequencer),
        .i_memData      (i_memData),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memData      (o_memData),
        .bytes          (bytes.source)
    );

    wordAssembler u_assembler (
        .clk    (clk),
        .rst    (rst),
        .bytes  (bytes.sink),
        .o_word (readWord)
    );
endmodule

`default_nettype wire

/* files.f */
common/memCtrlPkg.sv
common/memAccessIf.sv
common/byteStreamIf.sv
design/memArbiter.sv
memSeq/byteSequencer.sv
memSeq/wordAssembler.sv
design/memCtrlTop.sv
sim/ramModel.sv
sim/memCtrl_props.sv
sim/memCtrlTb.sv

/* memSeq/byteSequencer.sv */
`default_nettype none

module byteSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioBufferFull,

    memAccessIf.sequencer     acc,

    input  memCtrlPkg::byte_t i_memData,
    output logic              o_memWrite,
    output memCtrlPkg::addr_t o_memAddr,
    output memCtrlPkg::byte_t o_memData,

    byteStreamIf.source       bytes
);
    logic paused;
    logic isStore;
    logic beat;
    logic lastBeat;
    logic moreToIssue;
    memCtrlPkg::len_t issueCnt;
    memCtrlPkg::len_t recvCnt;
    // o_memAddr holds a read address this cycle
    logic rdAddrQ;
    // byte for last cycle's read arrives now
    logic inFlightQ;
    logic writeQ;

    assign paused = !i_rdy || i_ioBufferFull;
    assign isStore = acc.op == memCtrlPkg::opStore;

    // one byte moved, either received or written
    assign beat = !paused && (inFlightQ || writeQ);
    assign lastBeat = recvCnt == (acc.len - memCtrlPkg::len_t'(1));
    assign moreToIssue = issueCnt < acc.len;

    assign acc.done = beat && lastBeat;
    assign o_memWrite = writeQ && !paused;

    assign bytes.valid = inFlightQ && !paused;
    assign bytes.idx = recvCnt;
    assign bytes.data = i_memData;
    assign bytes.last = lastBeat;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt <= '0;
            recvCnt <= '0;
            rdAddrQ <= 1'b0;
            inFlightQ <= 1'b0;
            writeQ <= 1'b0;
            o_memAddr <= '0;
            o_memData <= '0;
        end else if (!acc.req || acc.done) begin
            issueCnt <= '0;
            recvCnt <= '0;
            rdAddrQ <= 1'b0;
            inFlightQ <= 1'b0;
            writeQ <= 1'b0;
        end else if (paused) begin
            // drop anything in the pipe, reissue from the first missing byte
            issueCnt <= recvCnt;
            rdAddrQ <= 1'b0;
            inFlightQ <= 1'b0;
            writeQ <= 1'b0;
        end else begin
            inFlightQ <= rdAddrQ;
            if (beat) begin
                recvCnt <= recvCnt + memCtrlPkg::len_t'(1);
            end
            if (moreToIssue) begin
                o_memAddr <= acc.addr + memCtrlPkg::addr_t'(issueCnt);
                issueCnt <= issueCnt + memCtrlPkg::len_t'(1);
                rdAddrQ <= !isStore;
                writeQ <= isStore;
                if (isStore) begin
                    o_memData <= memCtrlPkg::byte_t'(acc.wdata >> (memCtrlPkg::BYTE_W * issueCnt));
                end
            end else begin
                rdAddrQ <= 1'b0;
                writeQ <= 1'b0;
            end
        end
    end
endmodule

`default_nettype wire

/* memSeq/wordAssembler.sv */
`default_nettype none

module wordAssembler (
    input  logic              clk,
    input  logic              rst,
    byteStreamIf.sink         bytes,
    output memCtrlPkg::word_t o_word
);
    memCtrlPkg::byte_t held [memCtrlPkg::BYTES_PER_WORD];
    logic firstByte;

    assign firstByte = bytes.valid && (bytes.idx == '0);

    // last byte goes straight out, only earlier ones are kept
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < memCtrlPkg::BYTES_PER_WORD; i++) begin
                held[i] <= '0;
            end
        end else if (bytes.valid && !bytes.last) begin
            for (int i = 0; i < memCtrlPkg::BYTES_PER_WORD; i++) begin
                if (bytes.idx == memCtrlPkg::len_t'(i)) begin
                    held[i] <= bytes.data;
                end else if (firstByte) begin
                    held[i] <= '0;
                end
            end
        end
    end

    // merge stored bytes with the one arriving now
    always_comb begin
        for (int i = 0; i < memCtrlPkg::BYTES_PER_WORD; i++) begin
            if (bytes.valid && bytes.idx == memCtrlPkg::len_t'(i)) begin
                o_word[i*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = bytes.data;
            end else if (firstByte) begin
                // zero-extend short loads
                o_word[i*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = '0;
            end else begin
                o_word[i*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = held[i];
            end
        end
    end
endmodule

`default_nettype wire

/* sim/memCtrlTb.sv */
`default_nettype none

module memCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    memCtrlPkg::byte_t memRdData;
    logic memWrite;
    memCtrlPkg::addr_t memAddr;
    memCtrlPkg::byte_t memWrData;
    logic instEn;
    memCtrlPkg::addr_t instAddr;
    logic instDone;
    memCtrlPkg::word_t inst;
    logic dcEn;
    memCtrlPkg::lsSel_e dcLs;
    memCtrlPkg::len_t dcLen;
    memCtrlPkg::word_t dcData;
    memCtrlPkg::addr_t dcAddr;
    logic dcDone;
    memCtrlPkg::word_t dcRdData;

    memCtrlPkg::byte_t shadow [256];
    memCtrlPkg::word_t randWords [8];
    logic [15:0] lfsr;
    logic pauseOn;
    int valueErrors;
    int otherErrors;
    int assertErrors;

    memCtrlTop i_dut (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioBufferFull),
        .i_memData(memRdData), .o_memWrite(memWrite), .o_memAddr(memAddr),
        .o_memData(memWrData),
        .i_instEn(instEn), .i_instAddr(instAddr), .o_instDone(instDone), .o_inst(inst),
        .i_dcEn(dcEn), .i_dcLs(dcLs), .i_dcLen(dcLen), .i_dcData(dcData),
        .i_dcAddr(dcAddr), .o_dcDone(dcDone), .o_dcData(dcRdData)
    );

    ramModel u_ram (
        .clk(clk), .i_write(memWrite), .i_addr(memAddr), .i_data(memWrData),
        .o_data(memRdData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic memCtrlPkg::word_t randBits(input int n);
        memCtrlPkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    // little-endian word zero-extended above len
    function automatic memCtrlPkg::word_t shadowWord(input int addr, input int len);
        memCtrlPkg::word_t w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[i*8 +: 8] = shadow[addr + i];
        end
        return w;
    endfunction

    task automatic checkWord(input string name, input memCtrlPkg::word_t got,
                             input memCtrlPkg::word_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkByte(input string name, input memCtrlPkg::byte_t got,
                             input memCtrlPkg::byte_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error: %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic checkDone(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // outputs still held in reset
    task automatic resetCheck();
        checkDone("o_memWrite after reset", memWrite, 1'b0);
        checkDone("o_instDone after reset", instDone, 1'b0);
        checkDone("o_dcDone after reset", dcDone, 1'b0);
        checkWord("o_memAddr after reset", memCtrlPkg::word_t'(memAddr), '0);
        checkByte("o_memData after reset", memWrData, '0);
    endtask

    task automatic fetch(input int addr);
        memCtrlPkg::word_t got;
        @(negedge clk);
        instAddr = memCtrlPkg::addr_t'(addr);
        instEn = 1'b1;
        @(posedge clk);
        while (!instDone) begin
            @(posedge clk);
        end
        got = inst;
        @(negedge clk);
        instEn = 1'b0;
        @(posedge clk);
        checkDone("o_instDone after fetch", instDone, 1'b0);
        checkWord("o_inst", got, shadowWord(addr, 4));
    endtask

    task automatic dataAccess(input memCtrlPkg::lsSel_e ls, input int addr, input int len,
                              input memCtrlPkg::word_t wdata,
                              output memCtrlPkg::word_t rdata);
        @(negedge clk);
        dcLs = ls;
        dcAddr = memCtrlPkg::addr_t'(addr);
        dcLen = memCtrlPkg::len_t'(len);
        dcData = wdata;
        dcEn = 1'b1;
        @(posedge clk);
        while (!dcDone) begin
            @(posedge clk);
        end
        rdata = dcRdData;
        @(negedge clk);
        dcEn = 1'b0;
        @(posedge clk);
        checkDone("o_dcDone after access", dcDone, 1'b0);
    endtask

    task automatic loadCheck(input int addr, input int len);
        memCtrlPkg::word_t got;
        dataAccess(memCtrlPkg::lsLoad, addr, len, '0, got);
        checkWord("o_dcData", got, shadowWord(addr, len));
    endtask

    task automatic verifyArea(input int addr);
        memCtrlPkg::word_t got;
        dataAccess(memCtrlPkg::lsLoad, addr, 4, '0, got);
        for (int i = 0; i < 4; i++) begin
            checkByte($sformatf("o_dcData byte at 0x%02h", addr + i), got[i*8 +: 8],
                      shadow[addr + i]);
        end
    endtask

    task automatic storeCheck(input int addr, input int len, input memCtrlPkg::word_t data);
        memCtrlPkg::word_t ignored;
        dataAccess(memCtrlPkg::lsStore, addr, len, data, ignored);
        for (int i = 0; i < len; i++) begin
            shadow[addr + i] = data[i*8 +: 8];
        end
        // read back with neighbours on both sides
        verifyArea(addr - 2);
        verifyArea(addr + 2);
    endtask

    task automatic priorityPair(input int iAddr, input int dAddr);
        logic instSeen;
        logic dcSeen;
        logic dcFirst;
        logic dropInst;
        logic dropDc;
        memCtrlPkg::word_t instGot;
        memCtrlPkg::word_t dcGot;
        instSeen = 1'b0;
        dcSeen = 1'b0;
        dcFirst = 1'b0;
        @(negedge clk);
        instAddr = memCtrlPkg::addr_t'(iAddr);
        dcAddr = memCtrlPkg::addr_t'(dAddr);
        dcLs = memCtrlPkg::lsLoad;
        dcLen = memCtrlPkg::len_t'(4);
        instEn = 1'b1;
        dcEn = 1'b1;
        while (!(instSeen && dcSeen)) begin
            @(posedge clk);
            dropInst = instDone;
            dropDc = dcDone;
            if (dropDc) begin
                dcSeen = 1'b1;
                dcGot = dcRdData;
                dcFirst = !instSeen;
            end
            if (dropInst) begin
                instSeen = 1'b1;
                instGot = inst;
            end
            @(negedge clk);
            if (dropDc) begin
                dcEn = 1'b0;
            end
            if (dropInst) begin
                instEn = 1'b0;
            end
        end
        if (!dcFirst) begin
            otherErrors++;
            $display("the fetch finished before the data load that was raised with it");
        end
        checkWord("o_inst", instGot, shadowWord(iAddr, 4));
        checkWord("o_dcData", dcGot, shadowWord(dAddr, 4));
    endtask

    // no done may complete in a paused cycle
    always @(posedge clk) begin
        if (!rst && (!rdy || ioBufferFull)) begin
            checkDone("o_instDone in paused cycle", instDone, 1'b0);
            checkDone("o_dcDone in paused cycle", dcDone, 1'b0);
        end
    end

    always @(negedge clk) begin
        if (pauseOn) begin
            rdy = randBits(2) != 2'b11;
            ioBufferFull = randBits(3) == 3'b111;
        end else begin
            rdy = 1'b1;
            ioBufferFull = 1'b0;
        end
    end

    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 TEST_COUNT * CYCLES_PER_TEST);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        instEn = 1'b0;
        instAddr = '0;
        dcEn = 1'b0;
        dcLs = memCtrlPkg::lsLoad;
        dcLen = '0;
        dcData = '0;
        dcAddr = '0;
        pauseOn = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        assertErrors = 0;
        lfsr = 16'd2989;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = memCtrlPkg::byte_t'(a) ^ 8'hA5;
        end
        for (int k = 0; k < 8; k++) begin
            randWords[k] = randBits(32);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetCheck();
        rst = 1'b0;

        fetch(0);
        fetch(8);
        fetch(37);
        fetch(130);
        fetch(248);

        loadCheck(12, 1);
        loadCheck(13, 2);
        loadCheck(40, 4);
        loadCheck(91, 1);
        loadCheck(202, 2);
        loadCheck(203, 4);

        storeCheck(60, 1, randWords[0]);
        storeCheck(70, 2, randWords[1]);
        storeCheck(80, 4, randWords[2]);

        priorityPair(100, 140);
        priorityPair(20, 80);

        pauseOn = 1'b1;
        fetch(24);
        loadCheck(33, 1);
        loadCheck(45, 2);
        loadCheck(180, 4);
        storeCheck(150, 1, randWords[3]);
        storeCheck(160, 2, randWords[4]);
        storeCheck(170, 4, randWords[5]);
        fetch(160);
        loadCheck(81, 4);
        pauseOn = 1'b0;

        repeat (4) @(posedge clk);
        assertErrors = i_dut.u_props.failCount;
        $display("summary: %0d value errors, %0d other errors, %0d assertion failures",
                 valueErrors, otherErrors, assertErrors);
        if (valueErrors + otherErrors + assertErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* sim/memCtrl_props.sv */
`default_nettype none

module memCtrlProps (
    input logic               clk,
    input logic               rst,
    input logic               i_rdy,
    input logic               i_ioBufferFull,
    input logic               i_memWrite,
    input logic               i_instDone,
    input logic               i_dcDone,
    input logic               i_dcEn,
    input memCtrlPkg::lsSel_e i_dcLs
);
    timeunit 1ns;
    timeprecision 1ps;

    logic paused;
    int failCount = 0;

    assign paused = !i_rdy || i_ioBufferFull;

    noWriteWhenPaused: assert property (@(posedge clk) disable iff (rst)
        paused |-> !i_memWrite)
        else begin
            failCount++;
            $error("memory write in a paused cycle");
        end

    instDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        i_instDone |=> !i_instDone)
        else begin
            failCount++;
            $error("fetch done held longer than one cycle");
        end

    dcDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        i_dcDone |=> !i_dcDone)
        else begin
            failCount++;
            $error("data done held longer than one cycle");
        end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_instDone && i_dcDone))
        else begin
            failCount++;
            $error("fetch done and data done high together");
        end

    writeNeedsStore: assert property (@(posedge clk) disable iff (rst)
        i_memWrite |-> (i_dcEn && i_dcLs == memCtrlPkg::lsStore))
        else begin
            failCount++;
            $error("memory write without a pending store request");
        end
endmodule

bind memCtrlTop memCtrlProps u_props (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_memWrite     (o_memWrite),
    .i_instDone     (o_instDone),
    .i_dcDone       (o_dcDone),
    .i_dcEn         (i_dcEn),
    .i_dcLs         (i_dcLs)
);

`default_nettype wire

/* sim/ramModel.sv */
`default_nettype none

module ramModel (
    input  logic              clk,
    input  logic              i_write,
    input  memCtrlPkg::addr_t i_addr,
    input  memCtrlPkg::byte_t i_data,
    output memCtrlPkg::byte_t o_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // 256 bytes, so the low address byte is the whole address
    memCtrlPkg::byte_t mem [256];

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] = memCtrlPkg::byte_t'(a) ^ 8'hA5;
        end
        o_data = '0;
    end

    // read data one cycle after the address
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[7:0]] <= i_data;
        end
        o_data <= mem[i_addr[7:0]];
    end
endmodule

`default_nettype wire
